/* ipv4_pkg.sv */
/* IPv4 header layout and protocol constants for the checksum channels.
   Modules reach these by scoped names such as ipv4_pkg::ip_header_t. */

package ipv4_pkg;

    ////////////////////////////////////////////////////////////
    // Field types

    // 32-bit IPv4 address
    typedef logic [31:0] ip_addr_t;

    // Version and header length (IHL, in 32-bit words)
    typedef logic [3:0] ip_version_t;
    typedef logic [3:0] ip_ihl_t;

    ////////////////////////////////////////////////////////////
    // Header struct, fields in wire order so the MSB goes out first

    typedef struct packed {
        ip_version_t version;
        ip_ihl_t     ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        ip_addr_t    src_addr;
        ip_addr_t    dst_addr;
    } ip_header_t;

    ////////////////////////////////////////////////////////////
    // Protocol constants

    localparam ip_version_t IP_VERSION_4 = 4'd4;

    // No options supported, so 5 words is the only legal length
    localparam ip_ihl_t IP_IHL_MIN = 4'd5;

    // 20-byte header as 16-bit checksum words
    localparam int HEADER_WORDS = 10;

endpackage

/* csum_pkg.sv */
/* One's-complement checksum types, the receive status flags and the
   pipeline depth shared by both channels. */

package csum_pkg;

    // One 16-bit checksum word
    typedef logic [15:0] csum_word_t;

    // Ten words of 0xFFFF need 20 bits before folding
    typedef logic [19:0] csum_acc_t;

    // Receive-side result flags
    typedef struct packed {
        logic csum_ok;
        logic format_ok;
    } csum_status_t;

    // A correct header sums to negative zero
    localparam csum_word_t CSUM_ALL_ONES = 16'hFFFF;

    // Register stages per channel, also the channel latency
    localparam int PIPE_STAGES = 3;

endpackage

/* ipv4_header_sum.sv */
/* Two-stage one's-complement adder over the ten header words.
   The parent channel supplies the words and the pipeline advance enable. */
`timescale 1ns/1ps

module ipv4_header_sum (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              advance,
    input  csum_pkg::csum_word_t [ipv4_pkg::HEADER_WORDS-1:0] words,
    output csum_pkg::csum_word_t                              sum
);

    csum_pkg::csum_acc_t  part_lo;
    csum_pkg::csum_acc_t  part_hi;
    csum_pkg::csum_acc_t  part_lo_q;
    csum_pkg::csum_acc_t  part_hi_q;
    csum_pkg::csum_acc_t  total;
    csum_pkg::csum_acc_t  fold1;
    csum_pkg::csum_word_t fold2;

    ////////////////////////////////////////////////////////////
    // Stage 1: two partial sums of five words each

    always_comb begin
        part_lo = '0;
        part_hi = '0;
        for (int i = 0; i < ipv4_pkg::HEADER_WORDS / 2; i++) begin
            part_lo = part_lo + csum_pkg::csum_acc_t'(words[i]);
            part_hi = part_hi + csum_pkg::csum_acc_t'(words[i + ipv4_pkg::HEADER_WORDS / 2]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            part_lo_q <= '0;
            part_hi_q <= '0;
        end else if (advance) begin
            part_lo_q <= part_lo;
            part_hi_q <= part_hi;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2: add the halves and fold carries back in

    always_comb begin
        total = part_lo_q + part_hi_q;

        // First fold can leave a single carry in bit 16
        fold1 = csum_pkg::csum_acc_t'(total[15:0]) + csum_pkg::csum_acc_t'(total[19:16]);

        // Second fold cannot carry again since the low half is small when bit 16 is set
        fold2 = fold1[15:0] + csum_pkg::csum_word_t'(fold1[19:16]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum <= '0;
        end else if (advance) begin
            sum <= fold2;
        end
    end

endmodule

/* ipv4_checksum_verify.sv */
/* Receive channel: checks the header checksum and the version/length fields,
   then returns the header unchanged with a status word three stages later. */
`timescale 1ns/1ps

module ipv4_checksum_verify (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  ipv4_pkg::ip_header_t   in_header,
    output logic                   out_valid,
    input  logic                   out_ready,
    output ipv4_pkg::ip_header_t   out_header,
    output csum_pkg::csum_status_t out_status
);

    logic                                              advance;
    logic [csum_pkg::PIPE_STAGES-1:0]                  valid_q;
    csum_pkg::csum_word_t [ipv4_pkg::HEADER_WORDS-1:0] words;
    csum_pkg::csum_word_t                              sum;
    logic                                              fmt_in;
    logic                                              fmt1_q;
    logic                                              fmt2_q;
    ipv4_pkg::ip_header_t                              hdr1_q;
    ipv4_pkg::ip_header_t                              hdr2_q;

    ////////////////////////////////////////////////////////////
    // Flow control

    // Whole pipeline moves as one unless the output is stalled
    assign advance   = !out_valid || out_ready;
    assign in_ready  = advance;
    assign out_valid = valid_q[csum_pkg::PIPE_STAGES-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[csum_pkg::PIPE_STAGES-2:0], in_valid};
        end
    end

    ////////////////////////////////////////////////////////////
    // Sum over all ten words, checksum field included

    assign words = in_header;

    ipv4_header_sum u_header_sum (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .words   (words),
        .sum     (sum)
    );

    assign fmt_in = (in_header.version == ipv4_pkg::IP_VERSION_4) &&
                    (in_header.ihl == ipv4_pkg::IP_IHL_MIN);

    // Header and format flag ride alongside the sum stages
    always_ff @(posedge clk) begin
        if (advance) begin
            hdr1_q <= in_header;
            fmt1_q <= fmt_in;
            hdr2_q <= hdr1_q;
            fmt2_q <= fmt1_q;

            // Stage 3 output
            out_header           <= hdr2_q;
            out_status.csum_ok   <= (sum == csum_pkg::CSUM_ALL_ONES);
            out_status.format_ok <= fmt2_q;
        end
    end

    // A stalled result must stay put until the sink takes it
    a_hold_output : assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=>
            out_valid && $stable(out_header) && $stable(out_status)
    ) else $error("verify output changed while stalled");

endmodule

/* ipv4_checksum_insert.sv */
/* Transmit channel: computes the header checksum over the other nine words
   and writes it into the checksum field, three stages after acceptance. */
`timescale 1ns/1ps

module ipv4_checksum_insert (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  ipv4_pkg::ip_header_t in_header,
    output logic                 out_valid,
    input  logic                 out_ready,
    output ipv4_pkg::ip_header_t out_header
);

    logic                                              advance;
    logic [csum_pkg::PIPE_STAGES-1:0]                  valid_q;
    ipv4_pkg::ip_header_t                              hdr_zeroed;
    csum_pkg::csum_word_t [ipv4_pkg::HEADER_WORDS-1:0] words;
    csum_pkg::csum_word_t                              sum;
    ipv4_pkg::ip_header_t                              hdr1_q;
    ipv4_pkg::ip_header_t                              hdr2_q;
    ipv4_pkg::ip_header_t                              hdr_filled;

    // Full one's-complement fold of a header
    function automatic csum_pkg::csum_word_t fold_header(ipv4_pkg::ip_header_t hdr);
        csum_pkg::csum_word_t [ipv4_pkg::HEADER_WORDS-1:0] w;
        csum_pkg::csum_acc_t                               acc;
        w   = hdr;
        acc = '0;
        for (int i = 0; i < ipv4_pkg::HEADER_WORDS; i++) begin
            acc = acc + csum_pkg::csum_acc_t'(w[i]);
        end
        acc = csum_pkg::csum_acc_t'(acc[15:0]) + csum_pkg::csum_acc_t'(acc[19:16]);
        acc = csum_pkg::csum_acc_t'(acc[15:0]) + csum_pkg::csum_acc_t'(acc[19:16]);
        return acc[15:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Flow control

    assign advance   = !out_valid || out_ready;
    assign in_ready  = advance;
    assign out_valid = valid_q[csum_pkg::PIPE_STAGES-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[csum_pkg::PIPE_STAGES-2:0], in_valid};
        end
    end

    ////////////////////////////////////////////////////////////
    // Sum with the incoming checksum field treated as zero

    always_comb begin
        hdr_zeroed          = in_header;
        hdr_zeroed.checksum = '0;
    end

    assign words = hdr_zeroed;

    ipv4_header_sum u_header_sum (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .words   (words),
        .sum     (sum)
    );

    // Stage 3 writes the complemented sum, everything else passes through
    always_comb begin
        hdr_filled          = hdr2_q;
        hdr_filled.checksum = ~sum;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            hdr1_q     <= in_header;
            hdr2_q     <= hdr1_q;
            out_header <= hdr_filled;
        end
    end

    a_hold_output : assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_header)
    ) else $error("insert output changed while stalled");

    // Inserted checksum closes the header sum to all ones
    a_checksum_closes : assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> fold_header(out_header) == csum_pkg::CSUM_ALL_ONES
    ) else $error("inserted checksum does not close the header sum");

endmodule

/* ipv4_checksum_unit.sv */
/* Top level with independent receive (verify) and transmit (insert) channels,
   each a three-stage valid/ready pipeline carrying one header per transfer. */
`timescale 1ns/1ps

module ipv4_checksum_unit (
    input  logic                   clk,
    input  logic                   reset,

    // Receive channel
    input  logic                   rx_in_valid,
    output logic                   rx_in_ready,
    input  ipv4_pkg::ip_header_t   rx_in_header,
    output logic                   rx_out_valid,
    input  logic                   rx_out_ready,
    output ipv4_pkg::ip_header_t   rx_out_header,
    output csum_pkg::csum_status_t rx_out_status,

    // Transmit channel
    input  logic                   tx_in_valid,
    output logic                   tx_in_ready,
    input  ipv4_pkg::ip_header_t   tx_in_header,
    output logic                   tx_out_valid,
    input  logic                   tx_out_ready,
    output ipv4_pkg::ip_header_t   tx_out_header
);

    ////////////////////////////////////////////////////////////
    // Receive path

    ipv4_checksum_verify u_verify (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (rx_in_valid),
        .in_ready   (rx_in_ready),
        .in_header  (rx_in_header),
        .out_valid  (rx_out_valid),
        .out_ready  (rx_out_ready),
        .out_header (rx_out_header),
        .out_status (rx_out_status)
    );

    ////////////////////////////////////////////////////////////
    // Transmit path

    ipv4_checksum_insert u_insert (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (tx_in_valid),
        .in_ready   (tx_in_ready),
        .in_header  (tx_in_header),
        .out_valid  (tx_out_valid),
        .out_ready  (tx_out_ready),
        .out_header (tx_out_header)
    );

endmodule

/* tb_ipv4_model.svh */
/* Reference model for the checksum testbench: one's-complement sums, an LFSR
   for stimulus and the value check. Included inside the testbench module. */
`ifndef TB_IPV4_MODEL_SVH
`define TB_IPV4_MODEL_SVH

typedef logic [159:0] value_t;

logic [15:0] lfsr_state = 16'd58919;

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_step()};
    end
    return r;
endfunction

// End-around-carry sum over all ten 16-bit words
function automatic logic [15:0] ones_sum(input ipv4_pkg::ip_header_t h);
    int acc;
    acc = 0;
    for (int i = 0; i < 10; i++) begin
        acc = acc + int'(h[i*16 +: 16]);
    end
    while (acc > 32'hFFFF) begin
        acc = (acc & 32'hFFFF) + (acc >> 16);
    end
    return acc[15:0];
endfunction

// Checksum field value over the nine other words
function automatic logic [15:0] ref_checksum(input ipv4_pkg::ip_header_t h);
    ipv4_pkg::ip_header_t z;
    z          = h;
    z.checksum = '0;
    return ~ones_sum(z);
endfunction

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input value_t expected, input value_t actual);
    if (expected !== actual) begin
        fail_run($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
    end
endtask

`endif

/* tb_ipv4_checksum_unit.sv */
/* Directed testbench for the IPv4 checksum unit. Streams headers through the
   receive and transmit channels and compares them with the reference model. */
`timescale 1ns/1ps

module tb_ipv4_checksum_unit;

    localparam int LATENCY = 3;
    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   reset;
    logic                   rx_in_valid;
    logic                   rx_in_ready;
    ipv4_pkg::ip_header_t   rx_in_header;
    logic                   rx_out_valid;
    logic                   rx_out_ready;
    ipv4_pkg::ip_header_t   rx_out_header;
    csum_pkg::csum_status_t rx_out_status;
    logic                   tx_in_valid;
    logic                   tx_in_ready;
    ipv4_pkg::ip_header_t   tx_in_header;
    logic                   tx_out_valid;
    logic                   tx_out_ready;
    ipv4_pkg::ip_header_t   tx_out_header;

    int                   cycle;
    ipv4_pkg::ip_header_t rx_src[$];
    ipv4_pkg::ip_header_t tx_src[$];
    int                   rx_acc[$];
    int                   tx_acc[$];

    `include "tb_ipv4_model.svh"

    ipv4_checksum_unit u_ipv4_checksum_unit (.*);

    initial begin
        clk   = 1'b0;
        cycle = 0;
        forever begin
            #5 clk = ~clk;
            if (clk) cycle++;
        end
    end

    //////////////////////////////////////////////////////////////
    // Header generators

    function automatic ipv4_pkg::ip_header_t random_header();
        value_t bits;
        for (int i = 0; i < 5; i++) begin
            bits[i*32 +: 32] = lfsr_bits(32);
        end
        return ipv4_pkg::ip_header_t'(bits);
    endfunction

    function automatic ipv4_pkg::ip_header_t good_header();
        ipv4_pkg::ip_header_t h;
        h          = random_header();
        h.version  = 4'd4;
        h.ihl      = 4'd5;
        h.checksum = ref_checksum(h);
        return h;
    endfunction

    //////////////////////////////////////////////////////////////
    // Driver and checker

    // Drives the headers of one channel and holds valid until in_ready is seen
    task automatic send_all(input bit tx);
        int n;
        int waited;
        bit taken;
        n = tx ? tx_src.size() : rx_src.size();
        for (int i = 0; i < n; i++) begin
            if (tx) begin
                tx_in_valid  = 1'b1;
                tx_in_header = tx_src[i];
            end else begin
                rx_in_valid  = 1'b1;
                rx_in_header = rx_src[i];
            end
            waited = 0;
            taken  = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = tx ? tx_in_ready : rx_in_ready;
                if (taken) begin
                    if (tx) tx_acc.push_back(cycle);
                    else rx_acc.push_back(cycle);
                end else if (waited > TIMEOUT) begin
                    fail_run("Timeout waiting for in_ready on a channel input");
                end else begin
                    waited++;
                end
                @(posedge clk);
                #1;
            end
        end
        if (tx) tx_in_valid = 1'b0;
        else rx_in_valid = 1'b0;
    endtask

    // Compares each output header of both channels in arrival order
    task automatic collect_all(input string name, input bit stress);
        int                     rx_n;
        int                     tx_n;
        int                     idle;
        bit                     moved;
        ipv4_pkg::ip_header_t   exp;
        csum_pkg::csum_status_t st;
        rx_n = 0;
        tx_n = 0;
        idle = 0;
        while (rx_n < rx_src.size() || tx_n < tx_src.size()) begin
            rx_out_ready = stress ? lfsr_step() : 1'b1;
            tx_out_ready = stress ? lfsr_step() : 1'b1;
            @(negedge clk);
            moved = 1'b0;
            if (rx_out_valid && rx_out_ready) begin
                if (rx_n >= rx_src.size()) begin
                    fail_run("Receive channel returned a header that was never sent");
                end else begin
                    exp          = rx_src[rx_n];
                    st.csum_ok   = (ones_sum(exp) == 16'hFFFF);
                    st.format_ok = (exp.version == 4'd4) && (exp.ihl == 4'd5);
                    check_value({name, " rx header"}, exp, rx_out_header);
                    check_value({name, " rx status"}, value_t'(st), value_t'(rx_out_status));
                    if (!stress) begin
                        check_value({name, " rx latency"}, value_t'(LATENCY),
                                    value_t'(cycle - rx_acc[rx_n]));
                    end
                    rx_n++;
                    moved = 1'b1;
                end
            end
            if (tx_out_valid && tx_out_ready) begin
                if (tx_n >= tx_src.size()) begin
                    fail_run("Transmit channel returned a header that was never sent");
                end else begin
                    exp          = tx_src[tx_n];
                    exp.checksum = ref_checksum(exp);
                    check_value({name, " tx header"}, exp, tx_out_header);
                    if (!stress) begin
                        check_value({name, " tx latency"}, value_t'(LATENCY),
                                    value_t'(cycle - tx_acc[tx_n]));
                    end
                    tx_n++;
                    moved = 1'b1;
                end
            end
            idle = moved ? 0 : idle + 1;
            if (idle > TIMEOUT) begin
                fail_run("Timeout waiting for a header at a channel output");
            end
            @(posedge clk);
            #1;
        end
        rx_out_ready = 1'b1;
        tx_out_ready = 1'b1;
    endtask

    task automatic run_traffic(input string name, input bit stress);
        rx_acc.delete();
        tx_acc.delete();
        @(posedge clk);
        #1;
        fork
            send_all(1'b0);
            send_all(1'b1);
            collect_all(name, stress);
        join
        // Nothing extra may drain out once every header is back
        for (int i = 0; i <= LATENCY; i++) begin
            @(negedge clk);
            check_value({name, " rx idle"}, value_t'(0), value_t'(rx_out_valid));
            check_value({name, " tx idle"}, value_t'(0), value_t'(tx_out_valid));
        end
        rx_src.delete();
        tx_src.delete();
    endtask

    //////////////////////////////////////////////////////////////
    // Directed tests

    task automatic apply_reset();
        rx_out_ready = 1'b0;
        tx_out_ready = 1'b0;
        reset        = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("reset rx_out_valid", value_t'(0), value_t'(rx_out_valid));
        check_value("reset tx_out_valid", value_t'(0), value_t'(tx_out_valid));
        check_value("reset rx_in_ready", value_t'(1), value_t'(rx_in_ready));
        check_value("reset tx_in_ready", value_t'(1), value_t'(tx_in_ready));
    endtask

    task automatic insert_random_headers();
        for (int i = 0; i < 12; i++) tx_src.push_back(random_header());
        run_traffic("insert", 1'b0);
    endtask

    task automatic verify_correct_headers();
        for (int i = 0; i < 12; i++) rx_src.push_back(good_header());
        run_traffic("verify_good", 1'b0);
    endtask

    // Bad checksum, bad version and bad length in turn
    task automatic verify_corrupted_headers();
        ipv4_pkg::ip_header_t h;
        for (int i = 0; i < 12; i++) begin
            h = good_header();
            case (i % 3)
                0: h.checksum = h.checksum ^ (16'(lfsr_bits(16)) | 16'd1);
                1: h.version = h.version ^ (4'(lfsr_bits(4)) | 4'd1);
                default: h.ihl = h.ihl ^ (4'(lfsr_bits(4)) | 4'd1);
            endcase
            if (i % 3 != 0) h.checksum = ref_checksum(h);
            rx_src.push_back(h);
        end
        run_traffic("verify_bad", 1'b0);
    endtask

    task automatic stream_under_backpressure();
        for (int i = 0; i < 40; i++) begin
            rx_src.push_back((i % 2 == 0) ? good_header() : random_header());
            tx_src.push_back(random_header());
        end
        run_traffic("stream", 1'b1);
    endtask

    initial begin
        reset        = 1'b1;
        rx_in_valid  = 1'b0;
        rx_in_header = '0;
        rx_out_ready = 1'b0;
        tx_in_valid  = 1'b0;
        tx_in_header = '0;
        tx_out_ready = 1'b0;
        apply_reset();
        insert_random_headers();
        verify_correct_headers();
        verify_corrupted_headers();
        stream_under_backpressure();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* ipv4_checksum_unit.f */
+incdir+.
ipv4_pkg.sv
csum_pkg.sv
ipv4_header_sum.sv
ipv4_checksum_verify.sv
ipv4_checksum_insert.sv
ipv4_checksum_unit.sv
tb_ipv4_checksum_unit.sv

/* Makefile */
# Verilator flow for the IPv4 checksum unit
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= ipv4_checksum_unit.f
RTL_TOP   ?= ipv4_checksum_unit
TB_TOP    ?= tb_ipv4_checksum_unit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
